// File: flist.f
src/sigmoidPkg.sv
src/sigmoidTablePkg.sv
src/sigmoidFront.sv
src/sigmoidMultiplier.sv
src/sigmoidInterceptAdd.sv
src/sigmoidOutputPack.sv
src/sigmoid.sv
sim/sigmoid_sva.sv
sim/sigmoid_tb.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= sigmoid_tb
FLIST    ?= flist.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := >>> PASS
FAIL_MSG := >>> FAIL

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -F -q -e "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -F -q -e "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/sigmoid_tb.sv
`timescale 1ns/1ns

module sigmoid_tb;

	import sigmoidPkg::*;
	import sigmoidTablePkg::*;

	localparam int PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int SAMPLE_DELAY = 1;
	localparam int RESET_CYCLES = 8;
	localparam int PIPE_DEPTH = 6;
	localparam int NUM_RANDOM = 144;
	// 128 + 127 + 1 directed inputs plus the random run
	localparam int NUM_INPUTS = 256 + NUM_RANDOM;
	localparam int MARGIN = 50;
	// each input may carry up to two idle cycles in front of it
	localparam int WATCHDOG_NS = (RESET_CYCLES + 3 * NUM_INPUTS + PIPE_DEPTH + MARGIN) * PERIOD;

	logic clk;
	logic rstN;
	logic inValid;
	logic [XW-1:0] x;
	logic [YW-1:0] y;
	logic outValid;

	logic [YW-1:0] expQ[$];
	logic [YW-1:0] expHead;
	logic expAvail;
	int seed;
	int sentCount;
	int checkedCount;
	int mismatchCount;
	int otherCount;

	sigmoid sigmoid_i (
		.clk         (clk),
		.i_rstN      (rstN),
		.i_in_valid  (inValid),
		.i_x         (x),
		.o_y         (y),
		.o_out_valid (outValid)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// expected word: slope * low nibble + intercept, packed per sign
	function automatic logic [YW-1:0] expectedWord(input logic [XW-1:0] xIn);
		logic [7:0] mag;
		logic [2:0] segIdx;
		logic [7:0] prod;
		logic [9:0] func;
		logic [10:0] field;
		if (xIn == 8'h80) begin
			return SPECIAL_CODE;
		end
		mag = xIn[7] ? (8'd0 - xIn) : xIn;
		segIdx = mag[6:4];
		prod = {4'b0000, SLOPE_TABLE[segIdx]} * {4'b0000, mag[3:0]};
		func = INTERCEPT_TABLE[segIdx] + {2'b00, prod};
		field = {1'b1, func};
		if (xIn[7]) begin
			field = ~field;
		end
		return {1'b0, field, xIn[7], LOW_TAG};
	endfunction

	task automatic sendOne(input logic [XW-1:0] value);
		@(posedge clk);
		#DRIVE_DELAY;
		x = value;
		inValid = 1'b1;
		expQ.push_back(expectedWord(value));
		sentCount++;
	endtask

	// gap cycles still toggle the data lines
	task automatic idleCycles(input int count);
		int rnd;
		for (int n = 0; n < count; n++) begin
			rnd = $random(seed);
			@(posedge clk);
			#DRIVE_DELAY;
			inValid = 1'b0;
			x = rnd[7:0];
		end
	endtask

	task automatic runRandom(input int count);
		int rnd;
		for (int n = 0; n < count; n++) begin
			rnd = $random(seed);
			if (rnd[9:8] == 2'b00) begin
				idleCycles(int'(rnd[10]) + 1);
			end
			sendOne(rnd[7:0]);
		end
	endtask

	// take the next expected word once the output has settled
	always @(posedge clk) begin
		#SAMPLE_DELAY;
		if (outValid) begin
			if (expQ.size() > 0) begin
				expHead = expQ.pop_front();
				expAvail = 1'b1;
				checkedCount++;
			end else begin
				expAvail = 1'b0;
			end
		end
	end

	resultCheck: assert property (@(negedge clk) disable iff (!rstN) outValid |-> (y == expHead))
		else begin
			mismatchCount++;
			$display("mismatch at %0t: o_y expected %h actual %h", $time, expHead, y);
		end

	orderCheck: assert property (@(negedge clk) disable iff (!rstN) outValid |-> expAvail)
		else begin
			otherCount++;
			$display("error at %0t: o_out_valid high with no input left to match", $time);
		end

	initial begin
		#(WATCHDOG_NS);
		$display("error: watchdog timeout after %0d ns, results still missing", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		int totalErrors;
		seed = 32'hd0594f05;
		rstN = 1'b0;
		inValid = 1'b0;
		x = '0;
		expHead = '0;
		expAvail = 1'b1;
		sentCount = 0;
		checkedCount = 0;
		mismatchCount = 0;
		otherCount = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rstN = 1'b1;
		idleCycles(2);

		// all eight segments, positive side
		for (int v = 0; v < 128; v++) begin
			sendOne(8'(v));
		end
		idleCycles(3);

		// negative side, -1 down to -127
		for (int v = 1; v < 128; v++) begin
			sendOne(8'(-v));
		end
		idleCycles(1);

		sendOne(8'h80);
		runRandom(NUM_RANDOM);
		idleCycles(1);

		while (expQ.size() != 0) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);

		totalErrors = mismatchCount + otherCount + sigmoid_i.svaChecks.failCount;
		$display("errors: %0d mismatch, %0d other, %0d sva; %0d of %0d results checked",
			mismatchCount, otherCount, sigmoid_i.svaChecks.failCount, checkedCount, sentCount);
		if (totalErrors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: sim/sigmoid_sva.sv
`timescale 1ns/1ns

module sigmoid_sva (
	input logic        i_clk,
	input logic        i_rstN,
	input logic        i_in_valid,
	input logic [15:0] i_y,
	input logic        i_out_valid
);

	// register cuts between input and output
	localparam int PIPE_DEPTH = 6;

	int failCount;

	initial begin
		failCount = 0;
	end

	// outputs cleared on every reset edge, also seen on the first edge after release
	resetClear: assert property (@(posedge i_clk) !i_rstN |=> (!i_out_valid && i_y == '0))
		else begin
			failCount++;
			$error("reset did not clear o_y and o_out_valid");
		end

	// valid strobe and gaps come out six cuts later
	validDelay: assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_out_valid == $past(i_in_valid, PIPE_DEPTH))
		else begin
			failCount++;
			$error("o_out_valid does not follow i_in_valid by six cycles");
		end

endmodule

bind sigmoid sigmoid_sva svaChecks (
	.i_clk       (clk),
	.i_rstN      (i_rstN),
	.i_in_valid  (i_in_valid),
	.i_y         (o_y),
	.i_out_valid (o_out_valid)
);

// File: src/sigmoid.sv
`timescale 1ns/1ns

module sigmoid (
	input  logic                      clk,
	input  logic                      i_rstN,
	input  logic                      i_in_valid,
	input  logic [sigmoidPkg::XW-1:0] i_x,
	output logic [sigmoidPkg::YW-1:0] o_y,
	output logic                      o_out_valid
);

	import sigmoidPkg::*;

	// one struct per stage boundary
	frontOut_t frontData;
	mulOut_t mulData;
	addOut_t addData;

	// sign, magnitude, segment and slope
	sigmoidFront frontStage (
		.i_clk      (clk),
		.i_rstN     (i_rstN),
		.i_in_valid (i_in_valid),
		.i_x        (i_x),
		.o_front    (frontData)
	);

	// slope times low nibble
	sigmoidMultiplier mulStage (
		.i_clk   (clk),
		.i_rstN  (i_rstN),
		.i_front (frontData),
		.o_mul   (mulData)
	);

	// plus intercept
	sigmoidInterceptAdd addStage (
		.i_clk  (clk),
		.i_rstN (i_rstN),
		.i_mul  (mulData),
		.o_add  (addData)
	);

	// output encoding and the -128 case
	sigmoidOutputPack packStage (
		.i_clk       (clk),
		.i_rstN      (i_rstN),
		.i_add       (addData),
		.o_y         (o_y),
		.o_out_valid (o_out_valid)
	);

endmodule

// File: src/sigmoidOutputPack.sv
`timescale 1ns/1ns

module sigmoidOutputPack (
	input  logic                      i_clk,
	input  logic                      i_rstN,
	input  sigmoidPkg::addOut_t       i_add,
	output logic [sigmoidPkg::YW-1:0] o_y,
	output logic                      o_out_valid
);

	import sigmoidPkg::*;
	import sigmoidTablePkg::*;

	logic [FIELDW-1:0] field;
	logic [YW-1:0] word;

	// stage 5
	// negative inputs use 1 - f, which is the inverted field
	assign field = {1'b1, i_add.func} ^ {FIELDW{i_add.ctrl.sign}};

	always_comb begin
		if (i_add.ctrl.special) begin
			word = SPECIAL_CODE;
		end else begin
			// zero, field, sign, tag
			word = {1'b0, field, i_add.ctrl.sign, LOW_TAG};
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			o_y <= '0;
			o_out_valid <= 1'b0;
		end else begin
			o_y <= word;
			o_out_valid <= i_add.ctrl.valid;
		end
	end

endmodule

// File: src/sigmoidInterceptAdd.sv
`timescale 1ns/1ns

module sigmoidInterceptAdd (
	input  logic                i_clk,
	input  logic                i_rstN,
	input  sigmoidPkg::mulOut_t i_mul,
	output sigmoidPkg::addOut_t o_add
);

	import sigmoidPkg::*;
	import sigmoidTablePkg::*;

	logic [FUNCW-1:0] intercept;
	logic [FUNCW-1:0] sum;
	addOut_t addNext;

	// stage 4
	// intercept comes from the segment carried down the pipe
	assign intercept = interceptOf(i_mul.seg);

	// product tops out at 225, no carry out of ten bits
	assign sum = intercept + FUNCW'(i_mul.prod);

	always_comb begin
		addNext.ctrl = i_mul.ctrl;
		addNext.func = sum;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			o_add <= '0;
		end else begin
			o_add <= addNext;
		end
	end

endmodule

// File: src/sigmoidMultiplier.sv
`timescale 1ns/1ns

module sigmoidMultiplier (
	input  logic                  i_clk,
	input  logic                  i_rstN,
	input  sigmoidPkg::frontOut_t i_front,
	output sigmoidPkg::mulOut_t   o_mul
);

	import sigmoidPkg::*;

	// partial sums between the two multiply cuts
	typedef struct packed {
		pipeCtrl_t ctrl;
		segment_e seg;
		logic [PARTW-1:0] sumLo;
		logic [PARTW-1:0] sumHi;
	} partial_t;

	logic [NIBW-1:0] gated [SLOPEW];
	partial_t partNext;
	partial_t partReg;
	mulOut_t mulNext;

	// one nibble row per slope bit
	always_comb begin
		for (int k = 0; k < SLOPEW; k++) begin
			gated[k] = i_front.mag & {NIBW{i_front.slope[k]}};
		end
	end

	// stage 2
	// rows 0/1 and rows 2/3 summed pairwise
	always_comb begin
		partNext.ctrl = i_front.ctrl;
		partNext.seg = i_front.seg;
		partNext.sumLo = PARTW'(gated[0]) + (PARTW'(gated[1]) << 1);
		partNext.sumHi = PARTW'(gated[2]) + (PARTW'(gated[3]) << 1);
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			partReg <= '0;
		end else begin
			partReg <= partNext;
		end
	end

	// stage 3
	// upper pair weighs four times the lower one
	always_comb begin
		mulNext.ctrl = partReg.ctrl;
		mulNext.seg = partReg.seg;
		mulNext.prod = PRODW'(partReg.sumLo) + (PRODW'(partReg.sumHi) << 2);
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			o_mul <= '0;
		end else begin
			o_mul <= mulNext;
		end
	end

endmodule

// File: src/sigmoidFront.sv
`timescale 1ns/1ns

module sigmoidFront (
	input  logic                      i_clk,
	input  logic                      i_rstN,
	input  logic                      i_in_valid,
	input  logic [sigmoidPkg::XW-1:0] i_x,
	output sigmoidPkg::frontOut_t     o_front
);

	import sigmoidPkg::*;
	import sigmoidTablePkg::*;

	// first cut holds the raw sign and magnitude
	typedef struct packed {
		logic valid;
		logic sign;
		logic [MAGW-1:0] mag;
	} inStage_t;

	inStage_t inNext;
	inStage_t inReg;
	logic special;
	segment_e seg;
	frontOut_t frontNext;

	// stage 0
	// negative input is complemented and incremented, -128 stays 0x80
	always_comb begin
		inNext.valid = i_in_valid;
		inNext.sign = i_x[XW-1];
		if (i_x[XW-1]) begin
			inNext.mag = ~i_x + 1'b1;
		end else begin
			inNext.mag = i_x;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			inReg <= '0;
		end else begin
			inReg <= inNext;
		end
	end

	// stage 1
	// only -128 sets bit 7 of the magnitude together with the sign
	assign special = inReg.sign & inReg.mag[MAGW-1];
	assign seg = segment_e'(inReg.mag[6:4]);

	always_comb begin
		frontNext.ctrl.valid = inReg.valid;
		frontNext.ctrl.sign = inReg.sign;
		frontNext.ctrl.special = special;
		frontNext.mag = inReg.mag[NIBW-1:0];
		frontNext.seg = seg;
		// slope picked early so the multiply starts with it
		frontNext.slope = slopeOf(seg);
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			o_front <= '0;
		end else begin
			o_front <= frontNext;
		end
	end

endmodule

// File: src/sigmoidTablePkg.sv
package sigmoidTablePkg;

	import sigmoidPkg::*;

	// slope per segment, in units of 2^-3 down to 2^-6
	localparam logic [0:7][SLOPEW-1:0] SLOPE_TABLE = {
		4'd15,
		4'd14,
		4'd11,
		4'd8,
		4'd6,
		4'd4,
		4'd2,
		4'd1
	};

	// intercept per segment, 2^-2 down to 2^-11
	localparam logic [0:7][FUNCW-1:0] INTERCEPT_TABLE = {
		10'h003,
		10'h0FD,
		10'h1DE,
		10'h28F,
		10'h30B,
		10'h364,
		10'h3A2,
		10'h3C8
	};

	// result field is a leading one plus the function value
	localparam int FIELDW = FUNCW + 1;

	// fixed output word for an input of -128
	localparam logic [YW-1:0] SPECIAL_CODE = 16'h024D;

	// tag bits below the sign on every normal result
	localparam logic [2:0] LOW_TAG = 3'b011;

	function automatic logic [SLOPEW-1:0] slopeOf(input segment_e seg);
		return SLOPE_TABLE[seg];
	endfunction

	function automatic logic [FUNCW-1:0] interceptOf(input segment_e seg);
		return INTERCEPT_TABLE[seg];
	endfunction

endpackage

// File: src/sigmoidPkg.sv
package sigmoidPkg;

	// number format widths
	localparam int XW = 8;
	localparam int MAGW = 8;
	localparam int SLOPEW = 4;
	localparam int PARTW = 6;
	localparam int PRODW = 8;
	localparam int FUNCW = 10;
	localparam int YW = 16;

	// low magnitude bits that feed the multiplier
	localparam int NIBW = MAGW / 2;

	// segment code, straight from magnitude bits 6 to 4
	typedef enum logic [2:0] {
		seg0 = 3'd0,
		seg1 = 3'd1,
		seg2 = 3'd2,
		seg3 = 3'd3,
		seg4 = 3'd4,
		seg5 = 3'd5,
		seg6 = 3'd6,
		seg7 = 3'd7
	} segment_e;

	// control bits carried alongside every item
	typedef struct packed {
		logic valid;
		logic sign;
		logic special;
	} pipeCtrl_t;

	// front end to multiplier
	typedef struct packed {
		pipeCtrl_t ctrl;
		logic [NIBW-1:0] mag;
		segment_e seg;
		logic [SLOPEW-1:0] slope;
	} frontOut_t;

	// multiplier to intercept adder
	typedef struct packed {
		pipeCtrl_t ctrl;
		segment_e seg;
		logic [PRODW-1:0] prod;
	} mulOut_t;

	// intercept adder to output packer
	typedef struct packed {
		pipeCtrl_t ctrl;
		logic [FUNCW-1:0] func;
	} addOut_t;

endpackage
